// File: rtl/stripe_pkg.sv
package stripe_pkg;

  // geometry of the striped space
  localparam int NUM_SUBS   = 2;
  localparam int ADDR_W     = 8;
  localparam int DATA_W     = 16;
  localparam int STRB_W     = DATA_W / 8;
  localparam int ID_W       = 4;
  localparam int SEL_W      = 1;
  localparam int SUB_ADDR_W = ADDR_W - SEL_W;
  localparam int SUB_DEPTH  = 64;
  // byte-in-word bits sit below the stripe bits
  localparam int BYTE_SEL_W = $clog2(STRB_W);
  localparam int WORD_W     = $clog2(SUB_DEPTH);

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  typedef logic [ADDR_W-1:0]     axi_addr_t;
  typedef logic [SUB_ADDR_W-1:0] sub_addr_t;
  typedef logic [DATA_W-1:0]     axi_data_t;
  typedef logic [STRB_W-1:0]     axi_strb_t;
  typedef logic [ID_W-1:0]       axi_id_t;
  typedef logic [7:0]            axi_len_t;
  typedef logic [1:0]            axi_resp_t;
  typedef logic [SEL_W-1:0]      sub_sel_t;
  typedef logic [NUM_SUBS-1:0]   sub_mask_t;
  typedef logic [WORD_W-1:0]     sub_word_t;

  typedef struct packed {
    axi_id_t   id;
    axi_addr_t addr;
    axi_len_t  len;
  } aw_req_t;

  typedef struct packed {
    axi_id_t   id;
    sub_addr_t addr;
    axi_len_t  len;
  } sub_aw_t;

  typedef struct packed {
    axi_data_t data;
    axi_strb_t strb;
    logic      last;
  } w_beat_t;

  typedef struct packed {
    axi_id_t   id;
    axi_resp_t resp;
  } b_rsp_t;

  // one record per accepted burst, shared by W routing and B merging
  typedef struct packed {
    sub_sel_t  start_sub;
    sub_mask_t sub_mask;
    axi_id_t   id;
    axi_len_t  len;
  } burst_rec_t;

  typedef enum logic {
    B_COLLECT,
    B_RESPOND
  } b_state_t;

  typedef enum logic [1:0] {
    M_IDLE,
    M_BURST,
    M_RESP
  } mem_state_t;

endpackage

// File: rtl/axi_wr_mem.sv
`timescale 1ns/100ps

module axi_wr_mem (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  aw_valid,
  output logic                  aw_ready,
  input  stripe_pkg::sub_aw_t   aw,
  input  logic                  w_valid,
  output logic                  w_ready,
  input  stripe_pkg::w_beat_t   w,
  output logic                  b_valid,
  input  logic                  b_ready,
  output stripe_pkg::b_rsp_t    b,
  input  logic                  rd_en,
  input  stripe_pkg::sub_word_t rd_word,
  output stripe_pkg::axi_data_t rd_data
);

  stripe_pkg::axi_data_t        mem [stripe_pkg::SUB_DEPTH];
  stripe_pkg::mem_state_t       state;
  // extra top bit flags a burst that ran past the last word
  logic [stripe_pkg::WORD_W:0]  word;
  stripe_pkg::axi_id_t          id_q;
  logic                         err;
  logic                         w_hs;

  assign aw_ready = (state == stripe_pkg::M_IDLE);
  assign w_ready  = (state == stripe_pkg::M_BURST);
  assign b_valid  = (state == stripe_pkg::M_RESP);
  assign w_hs     = w_valid && w_ready;

  assign b.id   = id_q;
  assign b.resp = err ? stripe_pkg::RESP_SLVERR : stripe_pkg::RESP_OKAY;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= stripe_pkg::M_IDLE;
    end else begin
      case (state)
        stripe_pkg::M_IDLE: begin
          if (aw_valid) begin
            state <= stripe_pkg::M_BURST;
          end
        end
        stripe_pkg::M_BURST: begin
          if (w_hs && w.last) begin
            state <= stripe_pkg::M_RESP;
          end
        end
        default: begin
          if (b_ready) begin
            state <= stripe_pkg::M_IDLE;
          end
        end
      endcase
    end
  end

  // burst pointer, saturating once out of range
  always_ff @(posedge clk) begin
    if (aw_valid && aw_ready) begin
      word <= {1'b0, aw.addr[stripe_pkg::SUB_ADDR_W-1:stripe_pkg::BYTE_SEL_W]};
      id_q <= aw.id;
      err  <= 1'b0;
    end else if (w_hs) begin
      if (word[stripe_pkg::WORD_W]) begin
        err <= 1'b1;
      end else begin
        word <= word + 1'b1;
      end
    end
  end

  // excess beats are taken but never written
  always_ff @(posedge clk) begin
    if (w_hs && !word[stripe_pkg::WORD_W]) begin
      for (int i = 0; i < stripe_pkg::STRB_W; i++) begin
        if (w.strb[i]) begin
          mem[word[stripe_pkg::WORD_W-1:0]][i*8 +: 8] <= w.data[i*8 +: 8];
        end
      end
    end
    if (rd_en) begin
      rd_data <= mem[rd_word];
    end
  end

endmodule

// File: rtl/stripe_aw_split.sv
`timescale 1ns/100ps

module stripe_aw_split (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  logic                                          aw_valid,
  output logic                                          aw_ready,
  input  stripe_pkg::aw_req_t                           aw,
  output stripe_pkg::sub_mask_t                         sub_aw_valid,
  input  stripe_pkg::sub_mask_t                         sub_aw_ready,
  output stripe_pkg::sub_aw_t [stripe_pkg::NUM_SUBS-1:0] sub_aw,
  output logic                                          rec_valid,
  input  logic                                          w_rec_ready,
  input  logic                                          b_rec_ready,
  output stripe_pkg::burst_rec_t                        rec
);

  stripe_pkg::sub_sel_t                         start_sub;
  stripe_pkg::sub_addr_t                        base_addr;
  stripe_pkg::sub_aw_t [stripe_pkg::NUM_SUBS-1:0] split;
  stripe_pkg::sub_mask_t                        split_mask;

  // stripe bits sit just above the byte-in-word bits
  assign start_sub = aw.addr[stripe_pkg::BYTE_SEL_W +: stripe_pkg::SEL_W];
  assign base_addr = {aw.addr[stripe_pkg::ADDR_W-1:stripe_pkg::BYTE_SEL_W+stripe_pkg::SEL_W],
                      aw.addr[stripe_pkg::BYTE_SEL_W-1:0]};

  always_comb begin
    int total;
    int off;
    int cnt;
    total = int'(aw.len) + 1;
    for (int j = 0; j < stripe_pkg::NUM_SUBS; j++) begin
      // distance of sub j from the starting sub, in beats
      off = (j + stripe_pkg::NUM_SUBS - int'(start_sub)) % stripe_pkg::NUM_SUBS;
      cnt = total / stripe_pkg::NUM_SUBS + ((off < total % stripe_pkg::NUM_SUBS) ? 1 : 0);
      split_mask[j] = (cnt != 0);
      split[j].id   = aw.id;
      split[j].len  = stripe_pkg::axi_len_t'(cnt - 1);
      // subs before the start sub only see the burst from the next word on
      if (j < int'(start_sub)) begin
        split[j].addr = base_addr + stripe_pkg::sub_addr_t'(stripe_pkg::STRB_W);
      end else begin
        split[j].addr = base_addr;
      end
    end
  end

  // a new burst waits for both queues and for every sub AW to drain
  assign aw_ready  = w_rec_ready && b_rec_ready && (sub_aw_valid == '0);
  assign rec_valid = aw_valid && aw_ready;

  assign rec.start_sub = start_sub;
  assign rec.sub_mask  = split_mask;
  assign rec.id        = aw.id;
  assign rec.len       = aw.len;

  always_ff @(posedge clk) begin
    if (rec_valid) begin
      sub_aw <= split;
    end
  end

  // each sub drops out of the pending set on its own handshake
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sub_aw_valid <= '0;
    end else if (rec_valid) begin
      sub_aw_valid <= split_mask;
    end else begin
      sub_aw_valid <= sub_aw_valid & ~sub_aw_ready;
    end
  end

  for (genvar j = 0; j < stripe_pkg::NUM_SUBS; j++) begin : g_chk
    a_aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
      sub_aw_valid[j] && !sub_aw_ready[j] |=> sub_aw_valid[j] && $stable(sub_aw[j]));
  end

endmodule

// File: rtl/stripe_w_route.sv
`timescale 1ns/100ps

module stripe_w_route (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  logic                                          rec_valid,
  output logic                                          rec_ready,
  input  stripe_pkg::burst_rec_t                        rec,
  input  logic                                          w_valid,
  output logic                                          w_ready,
  input  stripe_pkg::w_beat_t                           w,
  output stripe_pkg::sub_mask_t                         sub_w_valid,
  input  stripe_pkg::sub_mask_t                         sub_w_ready,
  output stripe_pkg::w_beat_t [stripe_pkg::NUM_SUBS-1:0] sub_w
);

  stripe_pkg::burst_rec_t q [2];
  stripe_pkg::burst_rec_t head;
  logic                   wr_ptr;
  logic                   rd_ptr;
  logic [1:0]             count;
  logic [1:0]             count_next;
  logic                   head_valid;
  logic                   push;
  logic                   pop;
  logic                   w_hs;
  logic                   sub_last;
  stripe_pkg::sub_sel_t   off;
  stripe_pkg::sub_sel_t   cur;
  stripe_pkg::axi_len_t   beat_cnt;

  assign head       = q[rd_ptr];
  assign head_valid = (count != 2'd0);
  assign push       = rec_valid && rec_ready;

  // beat k of the burst lands on (start_sub + k) mod NUM_SUBS
  assign cur = stripe_pkg::sub_sel_t'((int'(head.start_sub) + int'(off)) % stripe_pkg::NUM_SUBS);
  // no later beat of this burst returns to the same sub
  assign sub_last = (int'(beat_cnt) + stripe_pkg::NUM_SUBS) > int'(head.len);

  assign w_ready    = head_valid && sub_w_ready[cur];
  assign w_hs       = w_valid && w_ready;
  assign pop        = w_hs && w.last;
  assign count_next = count + 2'(push) - 2'(pop);

  always_comb begin
    sub_w_valid = '0;
    if (head_valid && w_valid) begin
      sub_w_valid[cur] = 1'b1;
    end
    for (int j = 0; j < stripe_pkg::NUM_SUBS; j++) begin
      sub_w[j].data = w.data;
      sub_w[j].strb = w.strb;
      sub_w[j].last = sub_last;
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      q[wr_ptr] <= rec;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr    <= 1'b0;
      rd_ptr    <= 1'b0;
      count     <= 2'd0;
      rec_ready <= 1'b0;
      off       <= '0;
      beat_cnt  <= '0;
    end else begin
      wr_ptr    <= wr_ptr ^ push;
      rd_ptr    <= rd_ptr ^ pop;
      count     <= count_next;
      rec_ready <= (count_next != 2'd2);
      if (pop) begin
        off      <= '0;
        beat_cnt <= '0;
      end else if (w_hs) begin
        off      <= (off == stripe_pkg::sub_sel_t'(stripe_pkg::NUM_SUBS - 1)) ? '0 : off + 1'b1;
        beat_cnt <= beat_cnt + 1'b1;
      end
    end
  end

  // upstream wlast has to agree with the awlen of the queued burst
  a_w_rec: assert property (@(posedge clk) disable iff (!rst_n)
    w_valid && w_ready |-> head_valid && (w.last == (beat_cnt == head.len)));

endmodule

// File: rtl/stripe_b_merge.sv
`timescale 1ns/100ps

module stripe_b_merge (
  input  logic                                         clk,
  input  logic                                         rst_n,
  input  logic                                         rec_valid,
  output logic                                         rec_ready,
  input  stripe_pkg::burst_rec_t                       rec,
  input  stripe_pkg::sub_mask_t                        sub_b_valid,
  output stripe_pkg::sub_mask_t                        sub_b_ready,
  input  stripe_pkg::b_rsp_t [stripe_pkg::NUM_SUBS-1:0] sub_b,
  output logic                                         b_valid,
  input  logic                                         b_ready,
  output stripe_pkg::b_rsp_t                           b
);

  stripe_pkg::burst_rec_t q [2];
  stripe_pkg::burst_rec_t head;
  logic                   wr_ptr;
  logic                   rd_ptr;
  logic [1:0]             count;
  logic [1:0]             count_next;
  logic                   head_valid;
  logic                   push;
  logic                   pop;
  stripe_pkg::b_state_t   state;
  stripe_pkg::sub_mask_t  got;
  stripe_pkg::sub_mask_t  got_next;
  stripe_pkg::sub_mask_t  sub_hs;
  stripe_pkg::axi_resp_t  worst;
  stripe_pkg::axi_resp_t  worst_next;

  assign head       = q[rd_ptr];
  assign head_valid = (count != 2'd0);
  assign push       = rec_valid && rec_ready;
  assign pop        = b_valid && b_ready;
  assign count_next = count + 2'(push) - 2'(pop);

  // only the subs of the head burst that have not answered yet
  assign sub_b_ready = (state == stripe_pkg::B_COLLECT && head_valid) ?
                       (head.sub_mask & ~got) : '0;
  assign sub_hs      = sub_b_valid & sub_b_ready;
  assign got_next    = got | sub_hs;

  always_comb begin
    worst_next = worst;
    for (int j = 0; j < stripe_pkg::NUM_SUBS; j++) begin
      if (sub_hs[j] && sub_b[j].resp > worst_next) begin
        worst_next = sub_b[j].resp;
      end
    end
  end

  assign b_valid = (state == stripe_pkg::B_RESPOND);
  assign b.id    = head.id;
  assign b.resp  = worst;

  always_ff @(posedge clk) begin
    if (push) begin
      q[wr_ptr] <= rec;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr    <= 1'b0;
      rd_ptr    <= 1'b0;
      count     <= 2'd0;
      rec_ready <= 1'b0;
      state     <= stripe_pkg::B_COLLECT;
      got       <= '0;
      worst     <= stripe_pkg::RESP_OKAY;
    end else begin
      wr_ptr    <= wr_ptr ^ push;
      rd_ptr    <= rd_ptr ^ pop;
      count     <= count_next;
      rec_ready <= (count_next != 2'd2);
      case (state)
        stripe_pkg::B_COLLECT: begin
          got   <= got_next;
          worst <= worst_next;
          if (head_valid && got_next == head.sub_mask) begin
            state <= stripe_pkg::B_RESPOND;
          end
        end
        default: begin
          if (b_ready) begin
            state <= stripe_pkg::B_COLLECT;
            got   <= '0;
            worst <= stripe_pkg::RESP_OKAY;
          end
        end
      endcase
    end
  end

  a_b_rec: assert property (@(posedge clk) disable iff (!rst_n) b_valid |-> head_valid);

  // subs answer in burst order, so every sub B carries the head id
  for (genvar j = 0; j < stripe_pkg::NUM_SUBS; j++) begin : g_chk
    a_b_id: assert property (@(posedge clk) disable iff (!rst_n)
      sub_hs[j] |-> sub_b[j].id == head.id);
  end

endmodule

// File: rtl/stripe_rd_port.sv
`timescale 1ns/100ps

module stripe_rd_port (
  input  logic                                            clk,
  input  logic                                            rst_n,
  input  logic                                            rd_en,
  input  stripe_pkg::axi_addr_t                           rd_addr,
  output logic                                            rd_valid,
  output stripe_pkg::axi_data_t                           rd_data,
  output stripe_pkg::sub_mask_t                           sub_rd_en,
  output stripe_pkg::sub_word_t                           sub_rd_word,
  input  stripe_pkg::axi_data_t [stripe_pkg::NUM_SUBS-1:0] sub_rd_data
);

  stripe_pkg::sub_sel_t sel;
  stripe_pkg::sub_sel_t sel_q;

  // same map as the write side: stripe bits pick the sub, the rest the word
  assign sel         = rd_addr[stripe_pkg::BYTE_SEL_W +: stripe_pkg::SEL_W];
  assign sub_rd_word = rd_addr[stripe_pkg::ADDR_W-1:stripe_pkg::BYTE_SEL_W+stripe_pkg::SEL_W];
  assign sub_rd_en   = rd_en ? (stripe_pkg::sub_mask_t'(1) << sel) : '0;

  always_ff @(posedge clk) begin
    if (rd_en) begin
      sel_q <= sel;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_en;
    end
  end

  assign rd_data = sub_rd_data[sel_q];

endmodule

// File: rtl/stripe_wr_top.sv
`timescale 1ns/100ps

module stripe_wr_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  aw_valid,
  output logic                  aw_ready,
  input  stripe_pkg::aw_req_t   aw,
  input  logic                  w_valid,
  output logic                  w_ready,
  input  stripe_pkg::w_beat_t   w,
  output logic                  b_valid,
  input  logic                  b_ready,
  output stripe_pkg::b_rsp_t    b,
  input  logic                  rd_en,
  input  stripe_pkg::axi_addr_t rd_addr,
  output logic                  rd_valid,
  output stripe_pkg::axi_data_t rd_data
);

  stripe_pkg::sub_mask_t                          sub_aw_valid;
  stripe_pkg::sub_mask_t                          sub_aw_ready;
  stripe_pkg::sub_aw_t [stripe_pkg::NUM_SUBS-1:0]   sub_aw;
  stripe_pkg::sub_mask_t                          sub_w_valid;
  stripe_pkg::sub_mask_t                          sub_w_ready;
  stripe_pkg::w_beat_t [stripe_pkg::NUM_SUBS-1:0]   sub_w;
  stripe_pkg::sub_mask_t                          sub_b_valid;
  stripe_pkg::sub_mask_t                          sub_b_ready;
  stripe_pkg::b_rsp_t [stripe_pkg::NUM_SUBS-1:0]    sub_b;
  stripe_pkg::sub_mask_t                          sub_rd_en;
  stripe_pkg::sub_word_t                          sub_rd_word;
  stripe_pkg::axi_data_t [stripe_pkg::NUM_SUBS-1:0] sub_rd_data;
  logic                                           rec_valid;
  logic                                           w_rec_ready;
  logic                                           b_rec_ready;
  stripe_pkg::burst_rec_t                         rec;

  stripe_aw_split i_aw_split (
    .clk         (clk),
    .rst_n       (rst_n),
    .aw_valid    (aw_valid),
    .aw_ready    (aw_ready),
    .aw          (aw),
    .sub_aw_valid(sub_aw_valid),
    .sub_aw_ready(sub_aw_ready),
    .sub_aw      (sub_aw),
    .rec_valid   (rec_valid),
    .w_rec_ready (w_rec_ready),
    .b_rec_ready (b_rec_ready),
    .rec         (rec)
  );

  stripe_w_route i_w_route (
    .clk        (clk),
    .rst_n      (rst_n),
    .rec_valid  (rec_valid),
    .rec_ready  (w_rec_ready),
    .rec        (rec),
    .w_valid    (w_valid),
    .w_ready    (w_ready),
    .w          (w),
    .sub_w_valid(sub_w_valid),
    .sub_w_ready(sub_w_ready),
    .sub_w      (sub_w)
  );

  stripe_b_merge i_b_merge (
    .clk        (clk),
    .rst_n      (rst_n),
    .rec_valid  (rec_valid),
    .rec_ready  (b_rec_ready),
    .rec        (rec),
    .sub_b_valid(sub_b_valid),
    .sub_b_ready(sub_b_ready),
    .sub_b      (sub_b),
    .b_valid    (b_valid),
    .b_ready    (b_ready),
    .b          (b)
  );

  // one memory per stripe
  for (genvar j = 0; j < stripe_pkg::NUM_SUBS; j++) begin : g_mem
    axi_wr_mem i_mem (
      .clk     (clk),
      .rst_n   (rst_n),
      .aw_valid(sub_aw_valid[j]),
      .aw_ready(sub_aw_ready[j]),
      .aw      (sub_aw[j]),
      .w_valid (sub_w_valid[j]),
      .w_ready (sub_w_ready[j]),
      .w       (sub_w[j]),
      .b_valid (sub_b_valid[j]),
      .b_ready (sub_b_ready[j]),
      .b       (sub_b[j]),
      .rd_en   (sub_rd_en[j]),
      .rd_word (sub_rd_word),
      .rd_data (sub_rd_data[j])
    );
  end

  stripe_rd_port i_rd_port (
    .clk        (clk),
    .rst_n      (rst_n),
    .rd_en      (rd_en),
    .rd_addr    (rd_addr),
    .rd_valid   (rd_valid),
    .rd_data    (rd_data),
    .sub_rd_en  (sub_rd_en),
    .sub_rd_word(sub_rd_word),
    .sub_rd_data(sub_rd_data)
  );

endmodule

// File: bench/stripe_wr_check.sv
`timescale 1ns/100ps

module stripe_wr_check (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  aw_valid,
  input  logic                  aw_ready,
  input  stripe_pkg::aw_req_t   aw,
  input  logic                  w_valid,
  input  logic                  w_ready,
  input  stripe_pkg::w_beat_t   w,
  input  logic                  b_valid,
  input  logic                  b_ready,
  input  stripe_pkg::b_rsp_t    b,
  input  logic                  rd_en,
  input  stripe_pkg::axi_addr_t rd_addr,
  input  logic                  rd_valid,
  input  stripe_pkg::axi_data_t rd_data,
  input  stripe_pkg::axi_resp_t exp_resp,
  input  int                    test_num,
  input  logic                  test_done,
  input  logic                  all_done,
  output int                    err_count
);

  // one entry per global word, indexed by the address above the byte bits
  stripe_pkg::axi_data_t model_mem [stripe_pkg::NUM_SUBS*stripe_pkg::SUB_DEPTH];
  stripe_pkg::axi_id_t   id_q    [$];
  stripe_pkg::axi_resp_t resp_q  [$];
  int                    start_q [$];
  int                    beat;
  logic                  rd_pend;
  stripe_pkg::axi_addr_t rd_addr_q;
  logic                  first_live;
  int                    test_errs;
  int                    tests_run;
  int                    tests_failed;

  initial begin
    err_count    = 0;
    beat         = 0;
    rd_pend      = 1'b0;
    rd_addr_q    = '0;
    first_live   = 1'b0;
    test_errs    = 0;
    tests_run    = 0;
    tests_failed = 0;
  end

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("ERR %0t: %s expected %0h actual %0h", $time, name, exp, act);
    err_count++;
  endtask

  task automatic report_fault(input string msg);
    $display("%0t: %s", $time, msg);
    err_count++;
  endtask

  task automatic store_beat(input int g, input stripe_pkg::w_beat_t beat_in);
    // words past the top of the space are dropped by the subordinates
    if (g < stripe_pkg::NUM_SUBS * stripe_pkg::SUB_DEPTH) begin
      for (int i = 0; i < stripe_pkg::STRB_W; i++) begin
        if (beat_in.strb[i]) begin
          model_mem[g][i*8 +: 8] = beat_in.data[i*8 +: 8];
        end
      end
    end
  endtask

  always @(posedge clk) begin
    // handshake outputs stay low in reset and on the first cycle after it
    if (!rst_n || first_live) begin
      if (aw_ready || w_ready || b_valid || rd_valid) begin
        report_fault("handshake output high during or just after reset");
      end
    end
    first_live = !rst_n;
    if (rst_n) begin
      if (aw_valid && aw_ready) begin
        id_q.push_back(aw.id);
        resp_q.push_back(exp_resp);
        start_q.push_back(int'(aw.addr[stripe_pkg::ADDR_W-1:stripe_pkg::BYTE_SEL_W]));
      end
      if (w_valid && w_ready) begin
        if (start_q.size() == 0) begin
          report_fault("W beat accepted with no burst open");
        end else begin
          // beat k of the burst lands on global word start + k
          store_beat(start_q[0] + beat, w);
          beat++;
          if (w.last) begin
            void'(start_q.pop_front());
            beat = 0;
          end
        end
      end
      if (b_valid && id_q.size() == 0) begin
        report_fault("b_valid high with no burst outstanding");
      end else if (b_valid && b_ready) begin
        if (b.id !== id_q[0]) begin
          report_mismatch("b.id", 32'(id_q[0]), 32'(b.id));
        end
        if (b.resp !== resp_q[0]) begin
          report_mismatch("b.resp", 32'(resp_q[0]), 32'(b.resp));
        end
        void'(id_q.pop_front());
        void'(resp_q.pop_front());
      end
      // read data is due one cycle after rd_en
      if (rd_pend) begin
        if (rd_valid !== 1'b1) begin
          report_fault("rd_valid missing one cycle after rd_en");
        end
        if (rd_data !== model_mem[rd_addr_q[stripe_pkg::ADDR_W-1:stripe_pkg::BYTE_SEL_W]]) begin
          report_mismatch("rd_data",
                          32'(model_mem[rd_addr_q[stripe_pkg::ADDR_W-1:stripe_pkg::BYTE_SEL_W]]),
                          32'(rd_data));
        end
      end else if (rd_valid) begin
        report_fault("rd_valid high without a read request");
      end
      rd_pend   = rd_en;
      rd_addr_q = rd_addr;
      if (test_done) begin
        tests_run++;
        if (err_count == test_errs) begin
          $display("test %0d: ok", test_num);
        end else begin
          tests_failed++;
          $display("test %0d: FAILED with %0d errors", test_num, err_count - test_errs);
        end
        test_errs = err_count;
      end
      if (all_done) begin
        if (id_q.size() != 0) begin
          report_fault("burst left without a B response");
        end
        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, err_count);
      end
    end
  end

endmodule

// File: bench/stripe_wr_tb.sv
`timescale 1ns/100ps

module stripe_wr_tb;

  // one line of the case file
  typedef struct packed {
    stripe_pkg::axi_id_t         id;
    stripe_pkg::axi_addr_t       addr;
    stripe_pkg::axi_len_t        len;
    stripe_pkg::axi_data_t       seed;
    stripe_pkg::axi_strb_t       strb;
    logic                        stall;
    logic [2:0]                  nrd;
    stripe_pkg::axi_addr_t [3:0] rd;
    stripe_pkg::axi_resp_t       resp;
  } case_t;

  logic                  clk;
  logic                  rst_n;
  logic                  aw_valid;
  logic                  aw_ready;
  stripe_pkg::aw_req_t   aw;
  logic                  w_valid;
  logic                  w_ready;
  stripe_pkg::w_beat_t   w;
  logic                  b_valid;
  logic                  b_ready;
  stripe_pkg::b_rsp_t    b;
  logic                  rd_en;
  stripe_pkg::axi_addr_t rd_addr;
  logic                  rd_valid;
  stripe_pkg::axi_data_t rd_data;
  stripe_pkg::axi_resp_t exp_resp;
  int                    test_num;
  logic                  test_done;
  logic                  all_done;
  int                    err_count;
  case_t                 cases [$];
  int                    cycles;
  int                    limit;

  stripe_wr_top i_stripe_wr_top (
    .clk     (clk),
    .rst_n   (rst_n),
    .aw_valid(aw_valid),
    .aw_ready(aw_ready),
    .aw      (aw),
    .w_valid (w_valid),
    .w_ready (w_ready),
    .w       (w),
    .b_valid (b_valid),
    .b_ready (b_ready),
    .b       (b),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_valid(rd_valid),
    .rd_data (rd_data)
  );

  stripe_wr_check i_check (
    .clk      (clk),
    .rst_n    (rst_n),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .aw       (aw),
    .w_valid  (w_valid),
    .w_ready  (w_ready),
    .w        (w),
    .b_valid  (b_valid),
    .b_ready  (b_ready),
    .b        (b),
    .rd_en    (rd_en),
    .rd_addr  (rd_addr),
    .rd_valid (rd_valid),
    .rd_data  (rd_data),
    .exp_resp (exp_resp),
    .test_num (test_num),
    .test_done(test_done),
    .all_done (all_done),
    .err_count(err_count)
  );

  always #20 clk = ~clk;

  // run limit scales with the number of cases
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit != 0 && cycles >= limit) begin
      $display("timeout: run still going after %0d cycles", cycles);
      $display("Done: errors found");
      $finish;
    end
  end

  task automatic read_cases();
    int          fd;
    int          n;
    string       line;
    case_t       c;
    logic [31:0] f [12];
    fd = $fopen("bench/stripe_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open bench/stripe_cases.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        // lines starting with # hold the column legend
        if (line.len() > 0 && line.getc(0) != "#") begin
          n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                      f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11]);
          if (n == 12) begin
            c.id    = stripe_pkg::axi_id_t'(f[0]);
            c.addr  = stripe_pkg::axi_addr_t'(f[1]);
            c.len   = stripe_pkg::axi_len_t'(f[2]);
            c.seed  = stripe_pkg::axi_data_t'(f[3]);
            c.strb  = stripe_pkg::axi_strb_t'(f[4]);
            c.stall = f[5][0];
            c.nrd   = f[6][2:0];
            for (int i = 0; i < 4; i++) begin
              c.rd[i] = stripe_pkg::axi_addr_t'(f[7+i]);
            end
            c.resp  = stripe_pkg::axi_resp_t'(f[11]);
            cases.push_back(c);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic send_aw(input case_t c);
    aw_valid <= 1'b1;
    aw.id    <= c.id;
    aw.addr  <= c.addr;
    aw.len   <= c.len;
    do begin
      @(posedge clk);
    end while (!aw_ready);
    aw_valid <= 1'b0;
  endtask

  task automatic send_w(input case_t c);
    for (int k = 0; k <= int'(c.len); k++) begin
      // occasional idle cycle between beats
      if ($urandom % 4 == 0) begin
        w_valid <= 1'b0;
        @(posedge clk);
      end
      w_valid <= 1'b1;
      w.data  <= c.seed + stripe_pkg::axi_data_t'(k);
      w.strb  <= c.strb;
      w.last  <= (k == int'(c.len));
      do begin
        @(posedge clk);
      end while (!w_ready);
    end
    w_valid <= 1'b0;
  endtask

  task automatic wait_b(input logic stall);
    logic got;
    got = 1'b0;
    while (!got) begin
      b_ready <= stall ? ($urandom % 3 != 0) : 1'b1;
      @(posedge clk);
      got = b_valid && b_ready;
    end
    b_ready <= 1'b0;
  endtask

  task automatic run_case(input int t, input case_t c);
    test_num <= t;
    exp_resp <= c.resp;
    send_aw(c);
    send_w(c);
    wait_b(c.stall);
    for (int i = 0; i < int'(c.nrd); i++) begin
      rd_en   <= 1'b1;
      rd_addr <= c.rd[i];
      @(posedge clk);
    end
    rd_en <= 1'b0;
    // last read data is compared on this edge
    @(posedge clk);
    test_done <= 1'b1;
    @(posedge clk);
    test_done <= 1'b0;
  endtask

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    aw_valid  = 1'b0;
    aw        = '0;
    w_valid   = 1'b0;
    w         = '0;
    b_ready   = 1'b0;
    rd_en     = 1'b0;
    rd_addr   = '0;
    exp_resp  = '0;
    test_num  = 0;
    test_done = 1'b0;
    all_done  = 1'b0;
    cycles    = 0;
    limit     = 0;
    void'($urandom(20));
    read_cases();
    if (cases.size() == 0) begin
      $display("no test cases read, nothing to run");
      $display("Done: errors found");
      $finish;
    end else begin
      limit = 200 * (cases.size() + 1);
      repeat (10) @(posedge clk);
      rst_n <= 1'b1;
      repeat (4) @(posedge clk);
      foreach (cases[t]) begin
        run_case(t + 1, cases[t]);
      end
      all_done <= 1'b1;
      @(posedge clk);
      all_done <= 1'b0;
      @(posedge clk);
      if (err_count == 0) begin
        $display("Done: no errors");
      end else begin
        $display("Done: errors found");
      end
      $finish;
    end
  end

endmodule

// File: bench/stripe_cases.txt
# id addr len seed strb stall nrd rd0 rd1 rd2 rd3 resp, all fields hex
# len is beats minus one, nrd is how many of rd0..rd3 are read back
1 00 03 1000 3 0 4 00 02 04 06 0
2 12 02 2000 3 0 4 12 14 16 06 0
3 20 00 3000 3 0 4 20 12 14 04 0
4 22 00 4000 3 0 4 22 20 16 00 0
5 00 01 5a5a 1 0 4 00 02 04 06 0
6 04 00 c3c3 2 0 4 04 00 02 06 0
7 fa 03 7000 3 0 4 fa fc fe 00 2
8 30 00 8000 3 1 2 30 20 00 00 0
9 32 00 9000 3 1 2 32 30 00 00 0
a 34 00 a000 3 1 2 34 32 00 00 0
b 36 00 b000 3 1 2 36 34 00 00 0
c 38 00 c000 3 1 2 38 36 00 00 0

// File: compile.f
rtl/stripe_pkg.sv
rtl/axi_wr_mem.sv
rtl/stripe_aw_split.sv
rtl/stripe_w_route.sv
rtl/stripe_b_merge.sv
rtl/stripe_rd_port.sv
rtl/stripe_wr_top.sv
bench/stripe_wr_check.sv
bench/stripe_wr_tb.sv

// File: Makefile
# Verilator flow for the striped AXI write subsystem
TOP = stripe_wr_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wall -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log
